/* src/lane_cpu_settings.svh */
`ifndef LANE_CPU_SETTINGS_SVH
`define LANE_CPU_SETTINGS_SVH

// Word memory size
`define MEM_WORDS 256
`define MEM_AW    8

// Register file size
`define NUM_REGS  8

`endif

/* src/lane_cpu_pkg.sv */
`default_nettype none

package lane_cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  led_t;

  // Instruction kind from bits 31:28, unlisted codes run as no-ops
  typedef enum logic [3:0] {
    op_addi  = 4'h0,
    op_add   = 4'h1,
    op_sub   = 4'h2,
    op_and   = 4'h3,
    op_or    = 4'h4,
    op_xor   = 4'h5,
    op_load  = 4'h6,
    op_store = 4'h7,
    op_rdsw  = 4'h8,
    op_led   = 4'h9,
    op_halt  = 4'hf
  } opcode_t;

  // Sequencer states
  typedef enum logic [2:0] {
    st_fetch,
    st_wait,
    st_exec,
    st_mem,
    st_halt
  } cpu_state_t;

endpackage

`default_nettype wire

/* src/word_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lane_cpu_settings.svh"

module word_mem
  import lane_cpu_pkg::*;
(
  input  wire                fpga_clk1_50,
  input  wire [`MEM_AW-1:0]  mem_addr,
  input  wire                mem_rd,
  input  wire                mem_wr,
  input  wire [3:0]          mem_be,
  input  wire word_t         mem_wdata,
  output word_t              mem_rdata
);

  // One array per byte lane, lane 0 is the low byte
  logic [7:0] mem_array_0 [0:`MEM_WORDS-1];
  logic [7:0] mem_array_1 [0:`MEM_WORDS-1];
  logic [7:0] mem_array_2 [0:`MEM_WORDS-1];
  logic [7:0] mem_array_3 [0:`MEM_WORDS-1];

  // Lane writes, each gated by its own enable bit
  always @(posedge fpga_clk1_50)
  begin
    if (mem_wr && mem_be[0])
    begin
      mem_array_0[mem_addr] <= mem_wdata[7:0];
    end
    if (mem_wr && mem_be[1])
    begin
      mem_array_1[mem_addr] <= mem_wdata[15:8];
    end
    if (mem_wr && mem_be[2])
    begin
      mem_array_2[mem_addr] <= mem_wdata[23:16];
    end
    if (mem_wr && mem_be[3])
    begin
      mem_array_3[mem_addr] <= mem_wdata[31:24];
    end
  end

  // Registered read, holds its value until the next read strobe
  always_ff @(posedge fpga_clk1_50)
  begin
    if (mem_rd)
    begin
      mem_rdata <= {mem_array_3[mem_addr], mem_array_2[mem_addr],
                    mem_array_1[mem_addr], mem_array_0[mem_addr]};
    end
  end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lane_cpu_settings.svh"

module reg_file
  import lane_cpu_pkg::*;
(
  input  wire         fpga_clk1_50,
  input  wire         rst_n,
  input  wire [2:0]   rs1_addr,
  input  wire [2:0]   rs2_addr,
  input  wire [2:0]   rd_addr,
  input  wire         rd_we,
  input  wire word_t  rd_data,
  output word_t       rs1_data,
  output word_t       rs2_data
);

  word_t regs [0:`NUM_REGS-1];

  always_ff @(posedge fpga_clk1_50)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (rd_we && (rd_addr != 3'd0))
    begin
      // Register zero is never written
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational reads, register zero forced to zero
  assign rs1_data = (rs1_addr == 3'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 3'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lane_cpu_settings.svh"

module exec_unit
  import lane_cpu_pkg::*;
(
  input  wire                 fpga_clk1_50,
  input  wire                 rst_n,
  input  wire [3:0]           sw,
  output logic [`MEM_AW-1:0]  mem_addr,
  output logic                mem_rd,
  output logic                mem_wr,
  output logic [3:0]          mem_be,
  output word_t               mem_wdata,
  input  wire word_t          mem_rdata,
  output logic [2:0]          rs1_addr,
  output logic [2:0]          rs2_addr,
  output logic                rd_we,
  output logic [2:0]          rd_addr,
  output word_t               rd_data,
  input  wire word_t          rs1_data,
  input  wire word_t          rs2_data,
  output led_t                led,
  output logic                halted
);

  cpu_state_t          state;
  logic [`MEM_AW-1:0]  pc;
  word_t               instr;
  opcode_t             opcode;
  word_t               imm;
  word_t               alu_out;
  word_t               eff_addr;
  logic                writes_rd;

  // Field decode of the latched instruction
  assign opcode   = opcode_t'(instr[31:28]);
  assign rd_addr  = instr[26:24];
  assign rs1_addr = instr[22:20];
  assign rs2_addr = instr[18:16];
  assign imm      = {{16{instr[15]}}, instr[15:0]};

  // Word address for loads and stores
  assign eff_addr = rs1_data + imm;

  assign writes_rd = opcode inside {op_addi, op_add, op_sub, op_and, op_or, op_xor, op_rdsw};

  // ALU
  always_comb
  begin
    alu_out = '0;
    case (opcode)
      op_addi: alu_out = rs1_data + imm;
      op_add:  alu_out = rs1_data + rs2_data;
      op_sub:  alu_out = rs1_data - rs2_data;
      op_and:  alu_out = rs1_data & rs2_data;
      op_or:   alu_out = rs1_data | rs2_data;
      op_xor:  alu_out = rs1_data ^ rs2_data;
      op_rdsw: alu_out = {28'd0, sw};
      default: alu_out = '0;
    endcase
  end

  // Memory and register file strobes per state
  always_comb
  begin
    mem_addr  = pc;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    mem_be    = 4'b0000;
    // Store data always comes from rs2
    mem_wdata = rs2_data;
    rd_we     = 1'b0;
    rd_data   = alu_out;
    case (state)
      st_fetch:
      begin
        mem_rd = 1'b1;
      end
      st_exec:
      begin
        if (opcode == op_load)
        begin
          mem_addr = eff_addr[`MEM_AW-1:0];
          mem_rd   = 1'b1;
          mem_be   = 4'b1111;
        end
        else if (opcode == op_store)
        begin
          mem_addr = eff_addr[`MEM_AW-1:0];
          mem_wr   = 1'b1;
          mem_be   = 4'b1111;
        end
        else
        begin
          rd_we = writes_rd;
        end
      end
      st_mem:
      begin
        // Load data arrives here
        rd_we   = 1'b1;
        rd_data = mem_rdata;
      end
      default:
      begin
        mem_rd = 1'b0;
      end
    endcase
  end

  // Instruction latch
  always_ff @(posedge fpga_clk1_50)
  begin
    if (state == st_wait)
    begin
      instr <= mem_rdata;
    end
  end

  // Sequencer, PC, LEDs and halt flag
  always_ff @(posedge fpga_clk1_50)
  begin
    if (!rst_n)
    begin
      state  <= st_fetch;
      pc     <= '0;
      led    <= '0;
      halted <= 1'b0;
    end
    else
    begin
      case (state)
        st_fetch:
        begin
          state <= st_wait;
        end
        st_wait:
        begin
          pc    <= pc + 1'b1;
          state <= st_exec;
        end
        st_exec:
        begin
          state <= st_fetch;
          if (opcode == op_led)
          begin
            led <= rs1_data[7:0];
          end
          if (opcode == op_load)
          begin
            state <= st_mem;
          end
          else if (opcode == op_halt)
          begin
            state  <= st_halt;
            halted <= 1'b1;
          end
        end
        st_mem:
        begin
          state <= st_fetch;
        end
        st_halt:
        begin
          // Only reset leaves halt
          state <= st_halt;
        end
        default:
        begin
          state <= st_fetch;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/de10nano.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lane_cpu_settings.svh"

module de10nano
  import lane_cpu_pkg::*;
(
  input  wire        fpga_clk1_50,
  input  wire        rst_n,
  input  wire [3:0]  sw,
  output led_t       led,
  output logic       halted
);

  // Core to memory
  logic [`MEM_AW-1:0]  mem_addr;
  logic                mem_rd;
  logic                mem_wr;
  logic [3:0]          mem_be;
  word_t               mem_wdata;
  word_t               mem_rdata;

  // Core to register file
  logic [2:0]          rs1_addr;
  logic [2:0]          rs2_addr;
  logic [2:0]          rd_addr;
  logic                rd_we;
  word_t               rd_data;
  word_t               rs1_data;
  word_t               rs2_data;

  // Instance name mem gives the lane array path
  word_mem mem (
    .fpga_clk1_50,
    .mem_addr,
    .mem_rd,
    .mem_wr,
    .mem_be,
    .mem_wdata,
    .mem_rdata
  );

  reg_file regs (
    .fpga_clk1_50,
    .rst_n,
    .rs1_addr,
    .rs2_addr,
    .rd_addr,
    .rd_we,
    .rd_data,
    .rs1_data,
    .rs2_data
  );

  exec_unit core (
    .fpga_clk1_50,
    .rst_n,
    .sw,
    .mem_addr,
    .mem_rd,
    .mem_wr,
    .mem_be,
    .mem_wdata,
    .mem_rdata,
    .rs1_addr,
    .rs2_addr,
    .rd_we,
    .rd_addr,
    .rd_data,
    .rs1_data,
    .rs2_data,
    .led,
    .halted
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
  output logic fpga_clk1_50
);

  // 40 ns period
  localparam time HALF_PERIOD = 20ns;

  initial
  begin
    fpga_clk1_50 = 1'b0;
  end

  always #(HALF_PERIOD) fpga_clk1_50 = ~fpga_clk1_50;

endmodule

`default_nettype wire

/* test/tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lane_cpu_settings.svh"

module tb
  import lane_cpu_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int HALT_LIMIT     = 200;
  localparam int TIMEOUT_CYCLES = 1600;
  localparam logic [15:0] STORE_ADDR = 16'h00c0;

  logic        fpga_clk1_50;
  logic        rst_n;
  logic [3:0]  sw;
  led_t        led;
  logic        halted;

  word_t prog [$];
  int    test_errors = 0;
  int    pass_count  = 0;
  int    fail_count  = 0;
  int    cycle_count = 0;

  tb_clock clock_gen (
    .fpga_clk1_50
  );

  de10nano i_dut (
    .fpga_clk1_50,
    .rst_n,
    .sw,
    .led,
    .halted
  );

  // Global run limit
  always @(posedge fpga_clk1_50)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run exceeded %0d cycles, stopping", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // Instruction fields: op 31:28, rd 26:24, rs1 22:20, rs2 18:16, imm 15:0
  function automatic word_t encode(input opcode_t op, input logic [2:0] rd,
                                   input logic [2:0] rs1, input logic [2:0] rs2,
                                   input logic [15:0] imm);
    return {op, 1'b0, rd, 1'b0, rs1, 1'b0, rs2, imm};
  endfunction

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (exp !== act)
    begin
      $display("mismatch %s led expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_halted(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("mismatch %s halted expected %b actual %b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  // Program words, then a no-op fill keyed to the address
  task automatic load_memory();
    word_t w;
    for (int a = 0; a < `MEM_WORDS; a++)
    begin
      if (a < prog.size())
        w = prog[a];
      else
        w = {4'he, 12'h000, a[7:0], ~a[7:0]};
      i_dut.mem.mem_array_0[a] = w[7:0];
      i_dut.mem.mem_array_1[a] = w[15:8];
      i_dut.mem.mem_array_2[a] = w[23:16];
      i_dut.mem.mem_array_3[a] = w[31:24];
    end
  endtask

  task automatic start_program(input logic [3:0] sw_val);
    @(posedge fpga_clk1_50);
    rst_n <= 1'b0;
    @(posedge fpga_clk1_50);
    sw <= sw_val;
    @(negedge fpga_clk1_50);
    load_memory();
    repeat (RESET_CYCLES - 1) @(posedge fpga_clk1_50);
    rst_n <= 1'b1;
  endtask

  task automatic wait_halt(input string name);
    int count;
    count = 0;
    while (!halted && count < HALT_LIMIT)
    begin
      @(negedge fpga_clk1_50);
      count++;
    end
    if (!halted)
    begin
      $display("%s: program did not halt within %0d cycles", name, HALT_LIMIT);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      $display("%s: ok", name);
      pass_count++;
    end
    else
    begin
      $display("%s: failed with %0d errors", name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  task automatic test_add();
    word_t       rnd;
    logic [15:0] a;
    logic [15:0] b;
    word_t       sum;
    rnd = $urandom();
    a   = rnd[15:0];
    rnd = $urandom();
    b   = rnd[15:0];
    sum = sext16(a) + sext16(b);
    prog.delete();
    prog.push_back(encode(op_addi, 3'd1, 3'd0, 3'd0, a));
    prog.push_back(encode(op_addi, 3'd2, 3'd0, 3'd0, b));
    prog.push_back(encode(op_add, 3'd3, 3'd1, 3'd2, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd3, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    start_program(4'h0);
    wait_halt("add");
    check_led("add", sum[7:0], led);
    finish_test("add");
  endtask

  task automatic test_logic();
    word_t rnd;
    word_t a;
    word_t b;
    word_t res;
    rnd = $urandom();
    a   = sext16(rnd[15:0]);
    rnd = $urandom();
    b   = sext16(rnd[15:0]);
    // ((a & b) ^ (a | b)) - (a - b)
    res = ((a & b) ^ (a | b)) - (a - b);
    prog.delete();
    prog.push_back(encode(op_addi, 3'd1, 3'd0, 3'd0, a[15:0]));
    prog.push_back(encode(op_addi, 3'd2, 3'd0, 3'd0, b[15:0]));
    prog.push_back(encode(op_sub, 3'd3, 3'd1, 3'd2, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd3, 3'd0, 16'h0));
    prog.push_back(encode(op_and, 3'd4, 3'd1, 3'd2, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd4, 3'd0, 16'h0));
    prog.push_back(encode(op_or, 3'd5, 3'd1, 3'd2, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd5, 3'd0, 16'h0));
    prog.push_back(encode(op_xor, 3'd6, 3'd4, 3'd5, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd6, 3'd0, 16'h0));
    prog.push_back(encode(op_sub, 3'd7, 3'd6, 3'd3, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd7, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    start_program(4'h0);
    wait_halt("logic");
    check_led("logic", res[7:0], led);
    finish_test("logic");
  endtask

  task automatic test_store_load();
    word_t       rnd;
    logic [15:0] hi;
    logic [15:0] lo;
    word_t       w;
    rnd = $urandom();
    hi  = rnd[15:0];
    rnd = $urandom();
    lo  = rnd[15:0];
    w   = {hi, 16'h0000} + sext16(lo);
    prog.delete();
    prog.push_back(encode(op_addi, 3'd1, 3'd0, 3'd0, hi));
    // Sixteen doublings move hi into the upper half
    for (int i = 0; i < 16; i++)
      prog.push_back(encode(op_add, 3'd1, 3'd1, 3'd1, 16'h0));
    prog.push_back(encode(op_addi, 3'd2, 3'd0, 3'd0, lo));
    prog.push_back(encode(op_add, 3'd4, 3'd1, 3'd2, 16'h0));
    prog.push_back(encode(op_store, 3'd0, 3'd0, 3'd4, STORE_ADDR));
    prog.push_back(encode(op_load, 3'd5, 3'd0, 3'd0, STORE_ADDR));
    prog.push_back(encode(op_led, 3'd0, 3'd5, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    start_program(4'h0);
    wait_halt("store_load");
    check_led("store_load", w[7:0], led);
    check_byte("store_load lane 0", w[7:0], i_dut.mem.mem_array_0[STORE_ADDR[7:0]]);
    check_byte("store_load lane 1", w[15:8], i_dut.mem.mem_array_1[STORE_ADDR[7:0]]);
    check_byte("store_load lane 2", w[23:16], i_dut.mem.mem_array_2[STORE_ADDR[7:0]]);
    check_byte("store_load lane 3", w[31:24], i_dut.mem.mem_array_3[STORE_ADDR[7:0]]);
    finish_test("store_load");
  endtask

  task automatic test_switch();
    word_t      rnd;
    logic [3:0] sw_val;
    rnd    = $urandom();
    sw_val = rnd[3:0];
    prog.delete();
    prog.push_back(encode(op_rdsw, 3'd1, 3'd0, 3'd0, 16'h0));
    prog.push_back(encode(op_led, 3'd0, 3'd1, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    start_program(sw_val);
    wait_halt("switch");
    check_led("switch", {4'h0, sw_val}, led);
    finish_test("switch");
  endtask

  task automatic test_reg_zero();
    prog.delete();
    // Nonzero LEDs first so the zero read is visible
    prog.push_back(encode(op_addi, 3'd1, 3'd0, 3'd0, 16'h005a));
    prog.push_back(encode(op_led, 3'd0, 3'd1, 3'd0, 16'h0));
    prog.push_back(encode(op_addi, 3'd0, 3'd0, 3'd0, 16'h1234));
    prog.push_back(encode(op_led, 3'd0, 3'd0, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    // Would change the LEDs if the core ran past halt
    prog.push_back(encode(op_led, 3'd0, 3'd1, 3'd0, 16'h0));
    start_program(4'h0);
    wait_halt("reg_zero");
    check_led("reg_zero", 8'h00, led);
    check_halted("reg_zero", 1'b1, halted);
    repeat (10) @(negedge fpga_clk1_50);
    check_led("reg_zero hold", 8'h00, led);
    check_halted("reg_zero hold", 1'b1, halted);
    finish_test("reg_zero");
  endtask

  task automatic test_reset();
    word_t       rnd;
    logic [15:0] v;
    rnd = $urandom();
    v   = {rnd[15:1], 1'b1};
    prog.delete();
    prog.push_back(encode(op_addi, 3'd1, 3'd0, 3'd0, v));
    prog.push_back(encode(op_led, 3'd0, 3'd1, 3'd0, 16'h0));
    prog.push_back(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'h0));
    start_program(4'h0);
    wait_halt("reset");
    check_led("reset before", v[7:0], led);
    check_halted("reset before", 1'b1, halted);
    @(posedge fpga_clk1_50);
    rst_n <= 1'b0;
    repeat (2) @(negedge fpga_clk1_50);
    check_led("reset during", 8'h00, led);
    check_halted("reset during", 1'b0, halted);
    repeat (RESET_CYCLES - 1) @(posedge fpga_clk1_50);
    rst_n <= 1'b1;
    // Sample after the first edge with reset released
    repeat (2) @(negedge fpga_clk1_50);
    check_led("reset after", 8'h00, led);
    check_halted("reset after", 1'b0, halted);
    finish_test("reset");
  endtask

  initial
  begin
    void'($urandom(32'haf62a6c8));
    rst_n <= 1'b0;
    sw    <= 4'h0;
    test_add();
    test_logic();
    test_store_load();
    test_switch();
    test_reg_zero();
    test_reset();
    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/lane_cpu_pkg.sv
src/word_mem.sv
src/reg_file.sv
src/exec_unit.sv
src/de10nano.sv
test/tb_clock.sv
test/tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb -f tb.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0
